//--- source/control_cfg.svh
`ifndef CONTROL_CFG_SVH
`define CONTROL_CFG_SVH

// ***************************************************************************
// Instruction field widths and state encoding width
// ***************************************************************************

`define OPCODE_WIDTH 6
`define FUNCT_WIDTH 6
`define STATE_WIDTH 7

// ***************************************************************************
// Opcode values
// ***************************************************************************

`define OP_RTYPE 6'h00 // Function field selects the operation.
`define OP_BEQ 6'h04
`define OP_BNE 6'h05
`define OP_BLE 6'h06
`define OP_BGT 6'h07
`define OP_ADDI 6'h08 // Traps on signed overflow.
`define OP_ADDIU 6'h09

// ***************************************************************************
// Function values for R-type instructions
// ***************************************************************************

`define FN_SLL 6'h00
`define FN_SRL 6'h02
`define FN_SRA 6'h03
`define FN_SLLV 6'h04
`define FN_SRAV 6'h07
`define FN_JR 6'h08
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_SLT 6'h2a

`endif

//--- source/controlPkg.sv
`include "control_cfg.svh"

package controlPkg;

	// ***********************************************************************
	// Sequencer states and decoded instruction classes
	// ***********************************************************************

	typedef enum logic [`STATE_WIDTH-1:0] {
		stateReset = 7'd1,
		stateStart = 7'd2,
		stateWaitMemRead = 7'd3,
		stateDecode = 7'd4,
		stateAdd = 7'd5,
		stateWriteInReg = 7'd6,
		stateWait = 7'd7,
		stateAddi = 7'd8,
		stateWriteInRegAddi = 7'd9,
		stateWaitMemRead2 = 7'd10,
		stateAnd = 7'd11,
		stateSub = 7'd12,
		stateJr = 7'd16, // Codes 13 to 15 are unused.
		stateSll = 7'd17,
		stateSllWriteReg = 7'd18,
		stateSllv = 7'd19,
		stateSllvWriteReg = 7'd20,
		stateSra = 7'd21,
		stateSraOp = 7'd22,
		stateSraWriteReg = 7'd23,
		stateSllvOp = 7'd24,
		stateSllOp = 7'd25,
		stateSrav = 7'd26,
		stateSravOp = 7'd27,
		stateSravWriteReg = 7'd28,
		stateSrl = 7'd29,
		stateSrlOp = 7'd30,
		stateSrlWriteReg = 7'd31,
		stateSlt = 7'd32,
		stateOverflowExc = 7'd33,
		stateAddiu = 7'd34,
		stateBeq = 7'd35,
		stateBeqCompare = 7'd36,
		stateBne = 7'd37,
		stateBneCompare = 7'd38,
		stateBgt = 7'd39,
		stateBgtCompare = 7'd40,
		stateBle = 7'd41,
		stateBleCompare = 7'd42
	} stateType;

	typedef enum logic [4:0] {
		instUnknown, instAdd, instAnd, instSub, instSlt, instJr,
		instSll, instSrl, instSra, instSllv, instSrav,
		instAddi, instAddiu, instBeq, instBne, instBgt, instBle
	} instructionType;

	// ***********************************************************************
	// Datapath select and operation codes
	// ***********************************************************************

	typedef enum logic [1:0] {srcAPc = 2'd0, srcARegA = 2'd2} aluSrcAType;
	typedef enum logic [2:0] {
		srcBRegB = 3'd0, srcBFour = 3'd1, srcBSignImm = 3'd2, srcBBranchOffset = 3'd3
	} aluSrcBType;
	typedef enum logic [2:0] {
		pcSrcAluResult = 3'd0, pcSrcAluOut = 3'd1, pcSrcRegA = 3'd4
	} pcSourceType;
	typedef enum logic [2:0] {
		aluLoad = 3'd0, aluAdd = 3'd1, aluSub = 3'd2, aluAnd = 3'd3, aluCompare = 3'd7
	} aluOpType;
	typedef enum logic [3:0] {
		memToRegAluOut = 4'd0, memToRegShifter = 4'd4, memToRegLessThan = 4'd8
	} memToRegType;
	typedef enum logic [1:0] {
		regDstRt = 2'd0, regDstStackPointer = 2'd1, regDstRd = 2'd3
	} regDstType;
	typedef enum logic [2:0] {addrPc = 3'd0, addrExceptionVector = 3'd3} addressSourceType;
	typedef enum logic [2:0] {
		shiftIdle = 3'd0, shiftLoad = 3'd1, shiftLeft = 3'd2,
		shiftRightLogical = 3'd3, shiftRightArithmetic = 3'd4
	} shiftOpType;

	typedef struct packed {
		aluSrcAType aluSrcA;
		aluSrcBType aluSrcB;
		pcSourceType pcSource;
		aluOpType aluOp;
		logic pcWrite;
		logic irWrite;
		addressSourceType addressSource;
		memToRegType memToReg;
		logic writeRegA;
		logic writeRegB;
		logic aluOutWrite;
		regDstType regDst;
		logic regWrite;
		logic epcWrite;
		shiftOpType shiftControl;
		logic shiftSrc; // Shift input from B instead of A.
		logic shiftAmt; // Amount from shamt field instead of a register.
	} controlWordType;

	parameter controlWordType idleControl = '0; // Every code zero means inactive.

endpackage

//--- source/instructionDecoder.sv
`timescale 1ns/1ns
`include "control_cfg.svh"

module instructionDecoder import controlPkg::*; (
	input logic [`OPCODE_WIDTH-1:0] opCode,
	input logic [`FUNCT_WIDTH-1:0] funct,
	output instructionType instruction
);

	instructionType rTypeInstruction;

	// Function field only matters for R-type opcodes.
	always_comb begin
		case (funct)
			`FN_ADD: rTypeInstruction = instAdd;
			`FN_AND: rTypeInstruction = instAnd;
			`FN_SUB: rTypeInstruction = instSub;
			`FN_SLT: rTypeInstruction = instSlt;
			`FN_JR: rTypeInstruction = instJr;
			`FN_SLL: rTypeInstruction = instSll;
			`FN_SRL: rTypeInstruction = instSrl;
			`FN_SRA: rTypeInstruction = instSra;
			`FN_SLLV: rTypeInstruction = instSllv;
			`FN_SRAV: rTypeInstruction = instSrav;
			default: rTypeInstruction = instUnknown;
		endcase
	end

	always_comb begin
		case (opCode)
			`OP_RTYPE: instruction = rTypeInstruction;
			`OP_ADDI: instruction = instAddi;
			`OP_ADDIU: instruction = instAddiu;
			`OP_BEQ: instruction = instBeq;
			`OP_BNE: instruction = instBne;
			`OP_BGT: instruction = instBgt;
			`OP_BLE: instruction = instBle;
			default: instruction = instUnknown; // Falls through to the wait state.
		endcase
	end

endmodule

//--- source/controlSequencer.sv
`timescale 1ns/1ns

module controlSequencer import controlPkg::*; (
	input logic clock,
	input logic reset,
	input instructionType instruction,
	input logic overflow,
	output stateType state
);

	stateType nextState;

	always_ff @(posedge clock, posedge reset) begin
		if (reset) begin
			state <= stateReset;
		end else begin
			state <= nextState;
		end
	end

	// ***********************************************************************
	// Next-state logic
	// ***********************************************************************

	always_comb begin
		case (state)
			stateReset: nextState = stateStart;
			stateStart: nextState = stateWaitMemRead;
			stateWaitMemRead: nextState = stateWaitMemRead2;
			stateWaitMemRead2: nextState = stateDecode;
			stateDecode: begin
				case (instruction)
					instAdd: nextState = stateAdd;
					instAnd: nextState = stateAnd;
					instSub: nextState = stateSub;
					instSlt: nextState = stateSlt;
					instJr: nextState = stateJr;
					instSll: nextState = stateSll;
					instSrl: nextState = stateSrl;
					instSra: nextState = stateSra;
					instSllv: nextState = stateSllv;
					instSrav: nextState = stateSrav;
					instAddi: nextState = stateAddi;
					instAddiu: nextState = stateAddiu;
					instBeq: nextState = stateBeq;
					instBne: nextState = stateBne;
					instBgt: nextState = stateBgt;
					instBle: nextState = stateBle;
					default: nextState = stateWait; // Unknown writes nothing.
				endcase
			end

			stateAdd, stateAnd, stateSub: nextState = stateWriteInReg;

			stateSll: nextState = stateSllOp;
			stateSllOp: nextState = stateSllWriteReg;
			stateSrl: nextState = stateSrlOp;
			stateSrlOp: nextState = stateSrlWriteReg;
			stateSra: nextState = stateSraOp;
			stateSraOp: nextState = stateSraWriteReg;
			stateSllv: nextState = stateSllvOp;
			stateSllvOp: nextState = stateSllvWriteReg;
			stateSrav: nextState = stateSravOp;
			stateSravOp: nextState = stateSravWriteReg;

			// Only addi traps, addiu keeps the wrapped sum.
			stateAddi: nextState = overflow ? stateOverflowExc : stateWriteInRegAddi;
			stateAddiu: nextState = stateWriteInRegAddi;

			stateBeq: nextState = stateBeqCompare;
			stateBne: nextState = stateBneCompare;
			stateBgt: nextState = stateBgtCompare;
			stateBle: nextState = stateBleCompare;

			stateWait: nextState = stateStart;
			default: nextState = stateWait; // Write-back, compare, jr and slt end here.
		endcase
	end

endmodule

//--- source/controlWordGenerator.sv
`timescale 1ns/1ns

module controlWordGenerator import controlPkg::*; (
	input stateType state,
	input logic equal,
	input logic greaterThan,
	output controlWordType control
);

	logic immediateShift;
	logic registerShift;

	// Shift states grouped by where the shift amount comes from.
	assign immediateShift = state inside {stateSll, stateSllOp, stateSllWriteReg,
		stateSrl, stateSrlOp, stateSrlWriteReg, stateSra, stateSraOp, stateSraWriteReg};
	assign registerShift = state inside {stateSllv, stateSllvOp, stateSllvWriteReg,
		stateSrav, stateSravOp, stateSravWriteReg};

	always_comb begin
		control = idleControl;
		case (state)
			// ***************************************************************
			// Initialisation and fetch
			// ***************************************************************
			stateReset: begin
				control.regDst = regDstStackPointer; // Stack pointer and EPC init.
				control.regWrite = 1'b1;
				control.epcWrite = 1'b1;
			end
			stateStart: begin
				control.aluSrcB = srcBFour; // PC + 4.
				control.aluOp = aluAdd;
				control.pcWrite = 1'b1;
			end
			stateWaitMemRead2: control.irWrite = 1'b1;
			stateDecode: begin
				control.writeRegA = 1'b1;
				control.writeRegB = 1'b1;
			end

			// ***************************************************************
			// R-type
			// ***************************************************************
			stateAdd, stateAnd, stateSub: begin
				control.aluSrcA = srcARegA;
				control.aluOutWrite = 1'b1;
				case (state)
					stateAnd: control.aluOp = aluAnd;
					stateSub: control.aluOp = aluSub;
					default: control.aluOp = aluAdd;
				endcase
			end
			stateWriteInReg: begin
				control.regDst = regDstRd;
				control.regWrite = 1'b1;
			end
			stateSlt: begin
				control.aluSrcA = srcARegA;
				control.aluOp = aluCompare;
				control.memToReg = memToRegLessThan; // Result taken straight from the ALU flag.
				control.writeRegA = 1'b1;
				control.writeRegB = 1'b1;
				control.regDst = regDstRd;
				control.regWrite = 1'b1;
			end
			stateJr: begin
				control.pcSource = pcSrcRegA;
				control.pcWrite = 1'b1;
				control.writeRegA = 1'b1;
			end

			stateSll, stateSrl, stateSra, stateSllv, stateSrav: begin
				control.shiftControl = shiftLoad;
				control.writeRegB = 1'b1;
			end
			stateSllOp, stateSllvOp: control.shiftControl = shiftLeft;
			stateSrlOp: control.shiftControl = shiftRightLogical;
			stateSraOp, stateSravOp: control.shiftControl = shiftRightArithmetic;
			stateSllWriteReg, stateSllvWriteReg, stateSrlWriteReg,
			stateSraWriteReg, stateSravWriteReg: begin
				control.memToReg = memToRegShifter;
				control.regDst = regDstRd;
				control.regWrite = 1'b1;
				case (state)
					stateSrlWriteReg: control.shiftControl = shiftRightLogical;
					stateSraWriteReg, stateSravWriteReg: control.shiftControl = shiftRightArithmetic;
					default: control.shiftControl = shiftLeft;
				endcase
			end

			// ***************************************************************
			// Immediates and branches
			// ***************************************************************
			stateAddi, stateAddiu: begin
				control.aluSrcA = srcARegA;
				control.aluSrcB = srcBSignImm;
				control.aluOp = aluAdd;
				control.aluOutWrite = 1'b1;
			end
			stateWriteInRegAddi: control.regWrite = 1'b1; // Destination is rt.
			stateOverflowExc: begin
				control.addressSource = addrExceptionVector;
				control.epcWrite = 1'b1;
			end
			stateBeq, stateBne, stateBgt, stateBle: begin
				control.aluSrcB = srcBBranchOffset; // Target lands in ALUOut.
				control.aluOp = aluAdd;
				control.aluOutWrite = 1'b1;
			end
			stateBeqCompare, stateBneCompare, stateBgtCompare, stateBleCompare: begin
				control.aluSrcA = srcARegA;
				control.pcSource = pcSrcAluOut;
				control.aluOp = aluCompare;
				control.writeRegA = 1'b1;
				control.writeRegB = 1'b1;
				case (state)
					stateBeqCompare: control.pcWrite = equal;
					stateBneCompare: control.pcWrite = !equal;
					stateBgtCompare: control.pcWrite = greaterThan;
					default: control.pcWrite = !greaterThan;
				endcase
			end
			default: control = idleControl; // Wait and the first memory wait.
		endcase

		if (immediateShift) begin
			control.shiftSrc = 1'b1;
			control.shiftAmt = 1'b1;
		end
		if (registerShift) begin
			control.writeRegA = 1'b1; // A holds the amount, keep both loaded.
			control.writeRegB = 1'b1;
		end
	end

endmodule

//--- source/multicycleControl.sv
`timescale 1ns/1ns
`include "control_cfg.svh"

module multicycleControl import controlPkg::*; (
	input logic clock,
	input logic reset,
	input logic [`OPCODE_WIDTH-1:0] opCode,
	input logic [`FUNCT_WIDTH-1:0] funct,
	input logic overflow,
	input logic equal,
	input logic greaterThan,
	output aluSrcAType aluSrcA,
	output aluSrcBType aluSrcB,
	output pcSourceType pcSource,
	output aluOpType aluOp,
	output logic pcWrite,
	output logic irWrite,
	output addressSourceType addressSource,
	output memToRegType memToReg,
	output logic writeRegA,
	output logic writeRegB,
	output logic aluOutWrite,
	output regDstType regDst,
	output logic regWrite,
	output logic epcWrite,
	output shiftOpType shiftControl,
	output logic shiftSrc,
	output logic shiftAmt
);

	instructionType instruction;
	stateType state;
	controlWordType control;

	instructionDecoder instructionDecoder_i (
		.opCode(opCode),
		.funct(funct),
		.instruction(instruction)
	);

	controlSequencer controlSequencer_i (
		.clock(clock),
		.reset(reset),
		.instruction(instruction),
		.overflow(overflow),
		.state(state)
	);

	controlWordGenerator controlWordGenerator_i (
		.state(state),
		.equal(equal),
		.greaterThan(greaterThan),
		.control(control)
	);

	// Control word out to the datapath.
	assign aluSrcA = control.aluSrcA;
	assign aluSrcB = control.aluSrcB;
	assign pcSource = control.pcSource;
	assign aluOp = control.aluOp;
	assign pcWrite = control.pcWrite;
	assign irWrite = control.irWrite;
	assign addressSource = control.addressSource;
	assign memToReg = control.memToReg;
	assign writeRegA = control.writeRegA;
	assign writeRegB = control.writeRegB;
	assign aluOutWrite = control.aluOutWrite;
	assign regDst = control.regDst;
	assign regWrite = control.regWrite;
	assign epcWrite = control.epcWrite;
	assign shiftControl = control.shiftControl;
	assign shiftSrc = control.shiftSrc;
	assign shiftAmt = control.shiftAmt;

endmodule

//--- tests/multicycleControlTb.sv
`timescale 1ns/1ns
`include "control_cfg.svh"

module multicycleControlTb import controlPkg::*; ();

	localparam int testCount = 64;
	localparam int resetCycles = 16;
	localparam int maxLength = 12;

	logic clock;
	logic reset;
	logic [`OPCODE_WIDTH-1:0] opCode;
	logic [`FUNCT_WIDTH-1:0] funct;
	logic overflow;
	logic equal;
	logic greaterThan;
	aluSrcAType aluSrcA;
	aluSrcBType aluSrcB;
	pcSourceType pcSource;
	aluOpType aluOp;
	logic pcWrite;
	logic irWrite;
	addressSourceType addressSource;
	memToRegType memToReg;
	logic writeRegA;
	logic writeRegB;
	logic aluOutWrite;
	regDstType regDst;
	logic regWrite;
	logic epcWrite;
	shiftOpType shiftControl;
	logic shiftSrc;
	logic shiftAmt;

	integer seed = 38;
	int errorCount = 0;
	int phase = -1; // Cycles since the last Start.
	bit checking = 1'b0;
	instructionType inst = instUnknown;
	aluOpType expAluOp;
	shiftOpType expShift;
	logic expImmShift;
	logic expTaken;
	int expLength;

	logic [6:0] strobes;
	logic startMarker;
	logic isArith;
	logic isShift;
	logic isImm;
	logic isBranch;

	multicycleControl multicycleControl_i (.*);

	assign strobes = {pcWrite, irWrite, writeRegA, writeRegB, aluOutWrite, regWrite, epcWrite};
	assign startMarker = pcWrite && pcSource == pcSrcAluResult && aluSrcB == srcBFour;
	assign isArith = inst inside {instAdd, instAnd, instSub};
	assign isShift = inst inside {instSll, instSrl, instSra, instSllv, instSrav};
	assign isImm = inst inside {instAddi, instAddiu};
	assign isBranch = inst inside {instBeq, instBne, instBgt, instBle};

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	initial begin
		#((testCount * 10 + resetCycles + 4) * 4);
		$display("Watchdog timeout, the tests did not finish in time");
		$display("TB FAILED");
		$finish;
	end

	task automatic reportMismatch(input string name, input int expected, input int seen);
		$display("[FAIL] %0t ns: %s expected %0h, seen %0h", $time, name, expected, seen);
		errorCount++;
	endtask

	// ***********************************************************************
	// Checks sampled at the falling edge where outputs are settled
	// ***********************************************************************

	assert property (@(negedge clock) reset |-> strobes == 7'b0000011)
		else reportMismatch("strobes", 7'b0000011, strobes);
	assert property (@(negedge clock) reset |-> regDst == regDstStackPointer)
		else reportMismatch("regDst", regDstStackPointer, regDst);
	assert property (@(negedge clock) reset |-> {aluSrcA, aluSrcB, pcSource, aluOp,
		addressSource, memToReg, shiftControl, shiftSrc, shiftAmt} == '0)
		else reportMismatch("selects", 0, {aluSrcA, aluSrcB, pcSource, aluOp,
			addressSource, memToReg, shiftControl, shiftSrc, shiftAmt});
	assert property (@(negedge clock) disable iff (!checking) irWrite == (phase == 2))
		else reportMismatch("irWrite", phase == 2, irWrite);
	assert property (@(negedge clock) disable iff (!checking)
		phase == 3 |-> {writeRegA, writeRegB} == 2'b11)
		else reportMismatch("writeRegA/writeRegB", 2'b11, {writeRegA, writeRegB});

	assert property (@(negedge clock) disable iff (!checking)
		isArith && phase == 4 |-> aluOp == expAluOp)
		else reportMismatch("aluOp", expAluOp, aluOp);
	assert property (@(negedge clock) disable iff (!checking)
		isArith && phase == 4 |-> {aluSrcA, aluOutWrite} == {srcARegA, 1'b1})
		else reportMismatch("aluSrcA/aluOutWrite", {srcARegA, 1'b1}, {aluSrcA, aluOutWrite});
	assert property (@(negedge clock) disable iff (!checking)
		isArith && phase == 5 |-> {regWrite, regDst} == {1'b1, regDstRd})
		else reportMismatch("regWrite/regDst", {1'b1, regDstRd}, {regWrite, regDst});
	assert property (@(negedge clock) disable iff (!checking) inst == instSlt && phase == 4
		|-> {aluOp, memToReg, regWrite} == {aluCompare, memToRegLessThan, 1'b1})
		else reportMismatch("aluOp/memToReg/regWrite", {aluCompare, memToRegLessThan, 1'b1},
			{aluOp, memToReg, regWrite});

	assert property (@(negedge clock) disable iff (!checking)
		isShift && phase == 4 |-> shiftControl == shiftLoad)
		else reportMismatch("shiftControl", shiftLoad, shiftControl);
	assert property (@(negedge clock) disable iff (!checking)
		isShift && phase == 5 |-> shiftControl == expShift)
		else reportMismatch("shiftControl", expShift, shiftControl);
	assert property (@(negedge clock) disable iff (!checking) isShift && phase == 6
		|-> {shiftControl, regWrite, memToReg} == {expShift, 1'b1, memToRegShifter})
		else reportMismatch("shiftControl/regWrite/memToReg",
			{expShift, 1'b1, memToRegShifter}, {shiftControl, regWrite, memToReg});
	assert property (@(negedge clock) disable iff (!checking)
		isShift && phase inside {[4:6]} |-> {shiftSrc, shiftAmt} == {2{expImmShift}})
		else reportMismatch("shiftSrc/shiftAmt", {2{expImmShift}}, {shiftSrc, shiftAmt});

	assert property (@(negedge clock) disable iff (!checking) inst == instAddi && overflow
		&& phase == 5 |-> {epcWrite, addressSource, regWrite} == {1'b1, addrExceptionVector, 1'b0})
		else reportMismatch("epcWrite/addressSource/regWrite", {1'b1, addrExceptionVector, 1'b0},
			{epcWrite, addressSource, regWrite});
	assert property (@(negedge clock) disable iff (!checking) isImm && !(inst == instAddi
		&& overflow) && phase == 5 |-> {regWrite, regDst} == {1'b1, regDstRt})
		else reportMismatch("regWrite/regDst", {1'b1, regDstRt}, {regWrite, regDst});

	assert property (@(negedge clock) disable iff (!checking)
		isBranch && phase == 4 |-> aluSrcB == srcBBranchOffset)
		else reportMismatch("aluSrcB", srcBBranchOffset, aluSrcB);
	assert property (@(negedge clock) disable iff (!checking)
		isBranch && phase == 5 |-> {pcWrite, pcSource} == {expTaken, pcSrcAluOut})
		else reportMismatch("pcWrite/pcSource", {expTaken, pcSrcAluOut}, {pcWrite, pcSource});
	assert property (@(negedge clock) disable iff (!checking)
		inst == instJr && phase == 4 |-> {pcWrite, pcSource} == {1'b1, pcSrcRegA})
		else reportMismatch("pcWrite/pcSource", {1'b1, pcSrcRegA}, {pcWrite, pcSource});
	assert property (@(negedge clock) disable iff (!checking)
		inst == instUnknown && phase >= 4 |-> strobes == '0)
		else reportMismatch("strobes", 0, strobes);

	// ***********************************************************************
	// Stimulus
	// ***********************************************************************

	task automatic selectRType(input logic [`FUNCT_WIDTH-1:0] fn, input instructionType cls);
		opCode = `OP_RTYPE;
		funct = fn;
		inst = cls;
	endtask

	task automatic selectOpcode(input logic [`OPCODE_WIDTH-1:0] op, input instructionType cls);
		opCode = op;
		funct = 6'($random(seed)); // Ignored outside R-type.
		inst = cls;
	endtask

	task automatic chooseInstruction(input int test);
		int index;
		if (test < 34) begin
			index = test % 17; // Two passes over every class first.
			overflow = test >= 17;
			equal = test >= 17;
			greaterThan = test < 17;
		end else begin
			index = $unsigned($random(seed)) % 17;
			{overflow, equal, greaterThan} = 3'($random(seed));
		end
		case (index)
			0: selectRType(`FN_ADD, instAdd);
			1: selectRType(`FN_AND, instAnd);
			2: selectRType(`FN_SUB, instSub);
			3: selectRType(`FN_SLT, instSlt);
			4: selectRType(`FN_JR, instJr);
			5: selectRType(`FN_SLL, instSll);
			6: selectRType(`FN_SRL, instSrl);
			7: selectRType(`FN_SRA, instSra);
			8: selectRType(`FN_SLLV, instSllv);
			9: selectRType(`FN_SRAV, instSrav);
			10: selectOpcode(`OP_ADDI, instAddi);
			11: selectOpcode(`OP_ADDIU, instAddiu);
			12: selectOpcode(`OP_BEQ, instBeq);
			13: selectOpcode(`OP_BNE, instBne);
			14: selectOpcode(`OP_BGT, instBgt);
			15: selectOpcode(`OP_BLE, instBle);
			default: begin
				if (test % 2) selectOpcode(6'h3f, instUnknown);
				else selectRType(6'h3e, instUnknown);
			end
		endcase
		case (inst)
			instSlt, instJr: expLength = 6;
			instUnknown: expLength = 5;
			instSll, instSrl, instSra, instSllv, instSrav: expLength = 8;
			default: expLength = 7;
		endcase
		case (inst)
			instAnd: expAluOp = aluAnd;
			instSub: expAluOp = aluSub;
			default: expAluOp = aluAdd;
		endcase
		case (inst)
			instSrl: expShift = shiftRightLogical;
			instSra, instSrav: expShift = shiftRightArithmetic;
			default: expShift = shiftLeft;
		endcase
		expImmShift = inst inside {instSll, instSrl, instSra};
		case (inst)
			instBeq: expTaken = equal;
			instBne: expTaken = !equal;
			instBgt: expTaken = greaterThan;
			default: expTaken = !greaterThan;
		endcase
	endtask

	initial begin
		int length;
		int errorsBefore;
		int passedTests;
		int testsRun;
		passedTests = 0;
		testsRun = 0;
		reset = 1'b0;
		opCode = '0;
		funct = '0;
		overflow = 1'b0;
		equal = 1'b0;
		greaterThan = 1'b0;
		#1 reset = 1'b1;
		repeat (resetCycles) @(posedge clock);
		#1 reset = 1'b0;
		@(posedge clock);
		#1;
		if (!startMarker) begin
			$display("Start did not follow the end of reset");
			errorCount++;
		end
		for (int test = 0; test < testCount; test++) begin
			errorsBefore = errorCount;
			chooseInstruction(test);
			phase = 0;
			checking = 1'b1;
			length = 0;
			do begin
				@(posedge clock);
				#1;
				length++;
				phase = length;
			end while (!startMarker && length < maxLength);
			testsRun++;
			if (!startMarker) begin
				$display("%s never returned to Start", inst.name());
				errorCount++;
				break;
			end
			assert (length == expLength)
				else reportMismatch("cycle count", expLength, length);
			if (errorCount == errorsBefore) passedTests++;
			$display("test %0d %s: %0d cycles, %s", test, inst.name(), length,
				(errorCount == errorsBefore) ? "pass" : "fail");
		end
		$display("%0d of %0d tests passed, %0d errors", passedTests, testsRun, errorCount);
		if (errorCount == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- multicycleControl.f
+incdir+source
source/controlPkg.sv
source/instructionDecoder.sv
source/controlSequencer.sv
source/controlWordGenerator.sv
source/multicycleControl.sv
tests/multicycleControlTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module multicycleControlTb \
	-f multicycleControl.f \
	-o multicycleControlSim

./obj_dir/multicycleControlSim | tee sim.log

if grep -q "TB FAILED" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi

echo "Simulation finished without failure"
